// ==== bench/asi_model.svh ====
`ifndef ASI_MODEL_SVH
`define ASI_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference 8b/10b, RD- column written abcdei and fghj
////////////////////////////////////////////////////////////////////////////

localparam logic [5:0] code6_neg [32] = '{
	6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
	6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
	6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
	6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// Slot 7 holds the primary P7 code
localparam logic [3:0] code4_neg [8] = '{
	4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

// The line sends a first, so a goes to bit 0
function automatic logic [9:0] line_order(input logic [9:0] w);
	logic [9:0] s;
	for (int i = 0; i < 10; i++) begin
		s[i] = w[9-i];
	end
	return s;
endfunction

function automatic logic [9:0] model_data(input logic [7:0] b, input logic rd_pos);
	logic [5:0] c6;
	logic [3:0] c4;
	logic rd_mid;
	int x;
	int y;
	x = int'(b[4:0]);
	y = int'(b[7:5]);
	c6 = code6_neg[x];
	// Unbalanced codes and D.07 are complemented at RD+
	if (rd_pos && ($countones(c6) != 3 || x == 7)) begin
		c6 = ~c6;
	end
	rd_mid = rd_pos ^ ($countones(c6) != 3);
	c4 = code4_neg[y];
	// A7 where P7 would make five equal bits in a row
	if (y == 7 && (rd_mid ? (x == 11 || x == 13 || x == 14)
		: (x == 17 || x == 18 || x == 20))) begin
		c4 = 4'b0111;
	end
	if (rd_mid && ($countones(c4) != 2 || y == 3)) begin
		c4 = ~c4;
	end
	return line_order({c6, c4});
endfunction

// K28.5 is 001111 1010 at RD- and the complement at RD+
function automatic logic [9:0] model_comma(input logic rd_pos);
	return line_order(rd_pos ? 10'b1100000101 : 10'b0011111010);
endfunction

// Five ones always, six only from RD-, four only from RD+
function automatic logic disparity_ok(input logic [9:0] s, input logic rd_pos);
	return $countones(s) == 5 || ($countones(s) == 6 && !rd_pos) || ($countones(s) == 4 && rd_pos);
endfunction

function automatic logic next_rd(input logic [9:0] s, input logic rd_pos);
	return rd_pos ^ ($countones(s) != 5);
endfunction

`endif

// ==== bench/ts2asi_tb.sv ====
module ts2asi_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int fifo_depth = 16;
	localparam int pkt_len = 12;

	logic din_clk = 1'b0;
	logic rst_n;
	logic valid;
	logic [7:0] din_8b;
	logic asi_out;
	logic sym_start;
	logic ts_sync;
	logic error_full;
	logic error_empty;

	logic [31:0] seed = 32'h92d47e0b;
	// Accepted bytes not yet seen on the line
	logic [7:0] wq[$];
	// One data flag per take
	logic kinds[$];
	int count = 0;
	int n_written = 0;
	int n_acc = 0;
	int pop_idx = 0;
	int n_full_err = 0;
	int cyc = 0;
	logic rd_pos = 1'b0;
	logic [9:0] rx;

	`include "asi_model.svh"

	ts2asi #(
		.fifo_depth(fifo_depth),
		.pkt_len(pkt_len)
	) dut (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.valid(valid),
		.din_8b(din_8b),
		.asi_out(asi_out),
		.sym_start(sym_start),
		.ts_sync(ts_sync),
		.error_full(error_full),
		.error_empty(error_empty)
	);

	initial begin
		forever #50 din_clk = ~din_clk;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic check_symbol(input logic [9:0] s);
		logic [7:0] b;
		check_eq(32'(disparity_ok(s, rd_pos)), 32'd1, "ones count against disparity");
		if (kinds.pop_front()) begin
			b = wq.pop_front();
			check_eq(32'(s), 32'(model_data(b, rd_pos)), "data symbol");
		end else begin
			check_eq(32'(s), 32'(model_comma(rd_pos)), "comma symbol");
		end
		rd_pos = next_rd(s, rd_pos);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cycle model sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////

	task automatic observe_cycle();
		logic slot;
		logic take;
		logic pop;
		logic wr;
		// Encoder takes right after reset and at every slot start
		slot = (cyc >= 2) && ((cyc - 2) % 10 == 0);
		take = (cyc == 0) || slot;
		pop = take && (count > 0);
		wr = valid && (count < fifo_depth);
		check_eq(32'(sym_start), 32'(slot), "sym_start");
		check_eq(32'(error_empty), 32'd0, "error_empty");
		check_eq(32'(error_full), 32'(valid && !wr), "error_full");
		check_eq(32'(ts_sync), 32'(pop && (pop_idx % pkt_len == 0)), "ts_sync");
		if (error_full) n_full_err++;
		if (take) kinds.push_back(pop);
		if (pop) pop_idx++;
		count = count + int'(wr) - int'(pop);
		if (cyc < 2) begin
			check_eq(32'(asi_out), 32'd0, "asi_out before first slot");
		end else begin
			rx[(cyc - 2) % 10] = asi_out;
			if ((cyc - 2) % 10 == 9) check_symbol(rx);
		end
		cyc++;
		if (cyc > 20 * n_written + 2000) begin
			$display("Timeout after %0d cycles with %0d bytes still queued", cyc, wq.size());
			$display("*** FAILED ***");
			$fatal(1, "Run exceeded its cycle limit");
		end
	endtask

	always @(negedge din_clk) begin
		if (!rst_n) begin
			check_eq(32'({asi_out, sym_start, ts_sync, error_full, error_empty}), 32'd0,
				"outputs during reset");
		end else begin
			observe_cycle();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Valid on about hits out of fourteen cycles
	task automatic drive_phase(input int cycles, input int hits);
		logic [31:0] r;
		logic [7:0] b;
		for (int i = 0; i < cycles; i++) begin
			@(posedge din_clk);
			#1;
			r = lcg_next();
			valid = (int'(r[31:16]) % 14) < hits;
			if (valid) begin
				r = lcg_next();
				b = r[31:24];
				if (count < fifo_depth) begin
					// Packet position zero of the accepted stream
					if (n_acc % pkt_len == 0) b = 8'h47;
					wq.push_back(b);
					n_acc++;
				end
				din_8b = b;
				n_written++;
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		valid = 1'b0;
		din_8b = 8'h00;
		repeat (2) @(posedge din_clk);
		#1;
		rst_n = 1'b1;
		drive_phase(1500, 1);
		// Bursts well above the line rate
		drive_phase(600, 9);
		check_eq(32'(n_full_err > 0), 32'd1, "overflow seen in burst phase");
		drive_phase(1000, 1);
		@(posedge din_clk);
		#1;
		valid = 1'b0;
		while (wq.size() != 0) begin
			@(posedge din_clk);
		end
		repeat (30) @(posedge din_clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ts2asi testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
	--timescale 1ns/1ps \
	--top-module ts2asi_tb \
	-f ts2asi.f \
	-o ts2asi_sim

./obj_dir/ts2asi_sim

// ==== source/asi_pkg.sv ====
package asi_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	// One transport stream byte
	localparam int byte_w = 8;

	// One 8b/10b symbol
	localparam int sym_w = 10;

	// Serial slot length in din_clk cycles, one bit per clock
	localparam int bits_per_sym = 10;

	////////////////////////////////////////////////////////////////////////////
	// Stream constants
	////////////////////////////////////////////////////////////////////////////

	// Transport packet sync value
	localparam logic [byte_w-1:0] sync_byte = 8'h47;

	// K28.5 in line order, bit 0 is a and goes out first
	// RD- is 001111 1010 written abcdei fghj
	localparam logic [sym_w-1:0] k28_5_neg = 10'b0101111100;

	// RD+ is 110000 0101 written abcdei fghj
	localparam logic [sym_w-1:0] k28_5_pos = 10'b1010000011;

endpackage

// ==== source/asi_serializer.sv ====
module asi_serializer import asi_pkg::*; (
	input logic din_clk,
	input logic rst_n,
	input logic [sym_w-1:0] enc_sym,
	input logic full,
	output logic load,
	output logic asi_out,
	output logic sym_start
);

	localparam int cnt_w = $clog2(bits_per_sym);

	logic [cnt_w-1:0] slot_cnt;
	logic [sym_w-1:0] shreg;
	logic [sym_w-1:0] next_sym;
	// Disparity of the line after the last loaded symbol
	logic line_rd_pos;

	////////////////////////////////////////////////////////////////////////////
	// Slot timing
	////////////////////////////////////////////////////////////////////////////

	// Last cycle of a slot
	assign load = (slot_cnt == cnt_w'(bits_per_sym - 1));

	// Guard comma keeps the line balanced if the encoder has nothing
	assign next_sym = full ? enc_sym : (line_rd_pos ? k28_5_pos : k28_5_neg);

	// LSB first
	assign asi_out = shreg[0];

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			// Two cycles for the encoder to fill before the first slot
			slot_cnt <= cnt_w'(bits_per_sym - 2);
			shreg <= '0;
			sym_start <= 1'b0;
			line_rd_pos <= 1'b0;
		end else if (load) begin
			slot_cnt <= '0;
			shreg <= next_sym;
			sym_start <= 1'b1;
			line_rd_pos <= line_rd_pos ^ ($countones(next_sym) != 5);
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
			shreg <= shreg >> 1;
			sym_start <= 1'b0;
		end
	end

endmodule

// ==== source/enc_8b10b.sv ====
module enc_8b10b import asi_pkg::*; (
	input logic din_clk,
	input logic rst_n,
	sym_if.sink sym,
	output logic [sym_w-1:0] enc_sym,
	output logic full,
	input logic load
);

	////////////////////////////////////////////////////////////////////////////
	// Code tables, RD- column written abcdei and fghj
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [5:0] tab_5b6b(input logic [4:0] x);
		case (x)
			5'd0: return 6'b100111;
			5'd1: return 6'b011101;
			5'd2: return 6'b101101;
			5'd3: return 6'b110001;
			5'd4: return 6'b110101;
			5'd5: return 6'b101001;
			5'd6: return 6'b011001;
			5'd7: return 6'b111000;
			5'd8: return 6'b111001;
			5'd9: return 6'b100101;
			5'd10: return 6'b010101;
			5'd11: return 6'b110100;
			5'd12: return 6'b001101;
			5'd13: return 6'b101100;
			5'd14: return 6'b011100;
			5'd15: return 6'b010111;
			5'd16: return 6'b011011;
			5'd17: return 6'b100011;
			5'd18: return 6'b010011;
			5'd19: return 6'b110010;
			5'd20: return 6'b001011;
			5'd21: return 6'b101010;
			5'd22: return 6'b011010;
			5'd23: return 6'b111010;
			5'd24: return 6'b110011;
			5'd25: return 6'b100110;
			5'd26: return 6'b010110;
			5'd27: return 6'b110110;
			5'd28: return 6'b001110;
			5'd29: return 6'b101110;
			5'd30: return 6'b011110;
			default: return 6'b101011;
		endcase
	endfunction

	function automatic logic [3:0] tab_3b4b(input logic [2:0] y, input logic alt);
		case (y)
			3'd0: return 4'b1011;
			3'd1: return 4'b1001;
			3'd2: return 4'b0101;
			3'd3: return 4'b1100;
			3'd4: return 4'b1101;
			3'd5: return 4'b1010;
			3'd6: return 4'b0110;
			default: return alt ? 4'b0111 : 4'b1110;
		endcase
	endfunction

	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] c6_tab;
	logic [5:0] c6;
	logic [3:0] c4_tab;
	logic [3:0] c4;
	logic [sym_w-1:0] word;
	logic [sym_w-1:0] data_sym;
	logic [sym_w-1:0] next_sym;
	// Running disparity, low means negative
	logic rd_pos;
	// Disparity between the two sub-blocks
	logic rd_mid;
	logic alt7;

	assign x = sym.data[4:0];
	assign y = sym.data[7:5];

	// Output register free
	assign sym.take = sym.req && !full;

	////////////////////////////////////////////////////////////////////////////
	// Encoding
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Unbalanced codes and D.07 flip under RD+
		c6_tab = tab_5b6b(x);
		c6 = (rd_pos && (($countones(c6_tab) != 3) || x == 5'd7)) ? ~c6_tab : c6_tab;
		rd_mid = rd_pos ^ ($countones(c6) != 3);

		// A7 avoids a run of five equal bits across the sub-blocks
		alt7 = (y == 3'd7) && (rd_mid ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
			: (x == 5'd17 || x == 5'd18 || x == 5'd20));
		c4_tab = tab_3b4b(y, alt7);
		c4 = (rd_mid && (($countones(c4_tab) != 2) || y == 3'd3)) ? ~c4_tab : c4_tab;

		// Written order has a at the top, line order wants it at bit 0
		word = {c6, c4};
		for (int i = 0; i < sym_w; i++) begin
			data_sym[i] = word[sym_w-1-i];
		end

		if (sym.k) begin
			next_sym = rd_pos ? k28_5_pos : k28_5_neg;
		end else begin
			next_sym = data_sym;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register and disparity
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			full <= 1'b0;
			rd_pos <= 1'b0;
		end else begin
			if (sym.take) begin
				full <= 1'b1;
				// Any symbol not at five ones flips the disparity
				rd_pos <= rd_pos ^ ($countones(next_sym) != 5);
			end else if (load) begin
				full <= 1'b0;
			end
		end
	end

	always_ff @(posedge din_clk) begin
		if (sym.take) begin
			enc_sym <= next_sym;
		end
	end

endmodule

// ==== source/sym_if.sv ====
interface sym_if import asi_pkg::*; ();

	// Framer has a symbol to offer
	logic req;

	// Comma request instead of data
	logic k;

	// Data byte, valid when k is low
	logic [byte_w-1:0] data;

	// Encoder accepts the offer this cycle
	logic take;

	modport source (
		output req,
		output k,
		output data,
		input take
	);

	modport sink (
		input req,
		input k,
		input data,
		output take
	);

endinterface

// ==== source/ts2asi.sv ====
module ts2asi import asi_pkg::*; #(
	parameter int fifo_depth = 16,
	parameter int pkt_len = 188
) (
	input logic din_clk,
	input logic rst_n,
	input logic valid,
	input logic [byte_w-1:0] din_8b,
	output logic asi_out,
	output logic sym_start,
	output logic ts_sync,
	output logic error_full,
	output logic error_empty
);

	logic fifo_empty;
	logic [byte_w-1:0] fifo_data;
	logic fifo_pop;
	logic [sym_w-1:0] enc_sym;
	logic enc_full;
	logic ser_load;

	// Framer to encoder
	sym_if sym_bus ();

	////////////////////////////////////////////////////////////////////////////
	// Byte path
	////////////////////////////////////////////////////////////////////////////

	ts_fifo #(
		.fifo_depth(fifo_depth)
	) u_fifo (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.wr_en(valid),
		.wr_data(din_8b),
		.pop(fifo_pop),
		.rd_data(fifo_data),
		.empty(fifo_empty),
		.error_full(error_full),
		.error_empty(error_empty)
	);

	ts_framer #(
		.pkt_len(pkt_len)
	) u_framer (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.empty(fifo_empty),
		.rd_data(fifo_data),
		.pop(fifo_pop),
		.sym(sym_bus.source),
		.ts_sync(ts_sync)
	);

	////////////////////////////////////////////////////////////////////////////
	// Symbol path
	////////////////////////////////////////////////////////////////////////////

	enc_8b10b u_enc (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.sym(sym_bus.sink),
		.enc_sym(enc_sym),
		.full(enc_full),
		.load(ser_load)
	);

	asi_serializer u_ser (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.enc_sym(enc_sym),
		.full(enc_full),
		.load(ser_load),
		.asi_out(asi_out),
		.sym_start(sym_start)
	);

endmodule

// ==== source/ts_fifo.sv ====
module ts_fifo import asi_pkg::*; #(
	parameter int fifo_depth = 16
) (
	input logic din_clk,
	input logic rst_n,
	input logic wr_en,
	input logic [byte_w-1:0] wr_data,
	input logic pop,
	output logic [byte_w-1:0] rd_data,
	output logic empty,
	output logic error_full,
	output logic error_empty
);

	localparam int aw = $clog2(fifo_depth);

	logic [byte_w-1:0] mem [fifo_depth];

	// Extra top bit tells full from empty
	logic [aw:0] wr_ptr;
	logic [aw:0] rd_ptr;

	logic full;
	logic do_wr;
	logic do_rd;

	////////////////////////////////////////////////////////////////////////////
	// Status
	////////////////////////////////////////////////////////////////////////////

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

	assign do_wr = wr_en && !full;
	assign do_rd = pop && !empty;

	// Byte arriving on a full FIFO is lost
	assign error_full = wr_en && full;
	assign error_empty = pop && empty;

	// Head byte, valid while not empty
	assign rd_data = mem[rd_ptr[aw-1:0]];

	////////////////////////////////////////////////////////////////////////////
	// Pointers and storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge din_clk) begin
		if (do_wr) begin
			mem[wr_ptr[aw-1:0]] <= wr_data;
		end
	end

endmodule

// ==== source/ts_framer.sv ====
module ts_framer import asi_pkg::*; #(
	parameter int pkt_len = 188
) (
	input logic din_clk,
	input logic rst_n,
	input logic empty,
	input logic [byte_w-1:0] rd_data,
	output logic pop,
	sym_if.source sym,
	output logic ts_sync
);

	localparam int pos_w = $clog2(pkt_len);

	// Byte position inside the current packet, 0 expects a sync byte
	logic [pos_w-1:0] pos;
	logic locked;
	logic is_sync;
	logic last_pos;

	////////////////////////////////////////////////////////////////////////////
	// Offer to the encoder
	////////////////////////////////////////////////////////////////////////////

	// Always something to send, a data byte or a comma
	assign sym.req = 1'b1;
	assign sym.k = empty;
	assign sym.data = rd_data;

	// Data choice is committed on take
	assign pop = sym.take && !empty;

	////////////////////////////////////////////////////////////////////////////
	// Packet alignment
	////////////////////////////////////////////////////////////////////////////

	assign is_sync = (rd_data == sync_byte);
	assign last_pos = (pos == pos_w'(pkt_len - 1));

	// Sync in position, or first sync while hunting
	assign ts_sync = pop && is_sync && (!locked || pos == '0);

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			locked <= 1'b0;
			pos <= '0;
		end else if (pop) begin
			if (ts_sync) begin
				locked <= 1'b1;
				pos <= pos_w'(1);
			end else if (locked && pos == '0) begin
				// Missing sync, hunt for the next 0x47
				locked <= 1'b0;
			end else if (locked) begin
				pos <= last_pos ? '0 : pos + 1'b1;
			end
		end
	end

endmodule

// ==== ts2asi.f ====
+incdir+bench
source/asi_pkg.sv
source/sym_if.sv
source/ts_fifo.sv
source/ts_framer.sv
source/enc_8b10b.sv
source/asi_serializer.sv
source/ts2asi.sv
bench/ts2asi_tb.sv
